/* common/tile_pkg.sv */
// Tile memory fabric definitions
`default_nettype none

package tile_pkg;

  // Widths
  localparam int addr_width_c   = 40;
  localparam int data_width_c   = 64;
  localparam int did_width_c    = 16;
  localparam int dev_width_c    = 4;
  localparam int offset_width_c = 20;
  localparam int tile_width_c   = addr_width_c - dev_width_c - offset_width_c;

  typedef logic [did_width_c-1:0] did_t;
  typedef logic [dev_width_c-1:0] dev_id_t;
  typedef logic [offset_width_c-1:0] dev_offset_t;

  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_opcode_e;

  // Size is log2 of the access in bytes
  typedef struct packed
  {
    mem_opcode_e              opcode;
    logic [addr_width_c-1:0]  addr;
    logic [2:0]               size;
  } mem_header_t;

  typedef struct packed
  {
    mem_header_t              header;
    logic [data_width_c-1:0]  data;
  } mem_msg_t;

  // Local address split, device field sits at bits 23:20
  typedef struct packed
  {
    logic [tile_width_c-1:0]  tile;
    dev_id_t                  dev;
    dev_offset_t              offset;
  } local_addr_t;

  // Local device ids
  localparam dev_id_t clint_dev_c = 4'd1;
  localparam dev_id_t cfg_dev_c   = 4'd2;
  localparam dev_id_t cache_dev_c = 4'd3;

  // Everything from here up belongs to cache/DRAM space
  localparam logic [addr_width_c-1:0] dram_base_default_c = 40'h00_8000_0000;

  // CLINT register map
  localparam dev_offset_t msip_offset_c     = 20'h0_0000;
  localparam dev_offset_t mtimecmp_offset_c = 20'h0_4000;
  localparam dev_offset_t plic_offset_c     = 20'h0_B000;
  localparam dev_offset_t mtime_offset_c    = 20'h0_BFF8;

  // Configuration register map
  localparam dev_offset_t freeze_offset_c = 20'h0_0000;
  localparam dev_offset_t did_offset_c    = 20'h0_0008;

endpackage

`default_nettype wire

/* cfg/cfg_regs.sv */
// Tile configuration registers
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
  (
    input  wire                     clk_i,
    input  wire                     rst_n_i,

    input  wire tile_pkg::mem_msg_t cmd_i,
    input  wire                     cmd_v_i,
    output logic                    cmd_ready_o,

    output tile_pkg::mem_msg_t      resp_o,
    output logic                    resp_v_o,
    input  wire                     resp_ready_i,

    input  wire tile_pkg::did_t     did_i,
    output logic                    freeze_o
  );

  import tile_pkg::*;

  local_addr_t             cmd_addr;
  logic                    cmd_fire;
  logic                    cmd_wr;
  logic                    freeze_r;
  logic [data_width_c-1:0] rd_data;
  logic                    resp_v_r;
  mem_msg_t                resp_r;

  assign cmd_addr    = local_addr_t'(cmd_i.header.addr);
  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign cmd_wr      = (cmd_i.header.opcode == e_mem_wr);

  always_comb
  begin
    case (cmd_addr.offset)
      freeze_offset_c: rd_data = data_width_c'(freeze_r);
      did_offset_c:    rd_data = data_width_c'(did_i);
      default:         rd_data = '0;
    endcase
  end

  // Tile comes out of reset frozen
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r <= 1'b1;
    end
    else if (cmd_fire && cmd_wr && (cmd_addr.offset == freeze_offset_c))
    begin
      freeze_r <= cmd_i.data[0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r <= 1'b0;
    end
    else if (cmd_fire)
    begin
      resp_v_r <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_v_r <= 1'b0;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r <= '{header: cmd_i.header, data: (cmd_wr ? '0 : rd_data)};
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;
  assign freeze_o = freeze_r;

endmodule

`default_nettype wire

/* clint/clint_slice.sv */
// Machine timer and interrupt registers
`timescale 1ns/1ps
`default_nettype none

module clint_slice
  (
    input  wire                     clk_i,
    input  wire                     rst_n_i,

    input  wire tile_pkg::mem_msg_t cmd_i,
    input  wire                     cmd_v_i,
    output logic                    cmd_ready_o,

    output tile_pkg::mem_msg_t      resp_o,
    output logic                    resp_v_o,
    input  wire                     resp_ready_i,

    input  wire                     freeze_i,

    output logic                    timer_irq_o,
    output logic                    software_irq_o,
    output logic                    external_irq_o
  );

  import tile_pkg::*;

  local_addr_t             cmd_addr;
  logic                    cmd_fire;
  logic                    cmd_wr;
  logic [data_width_c-1:0] mtime_r;
  logic [data_width_c-1:0] mtimecmp_r;
  logic                    msip_r;
  logic                    plic_r;
  logic [data_width_c-1:0] rd_data;
  logic                    resp_v_r;
  mem_msg_t                resp_r;

  assign cmd_addr    = local_addr_t'(cmd_i.header.addr);
  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign cmd_wr      = (cmd_i.header.opcode == e_mem_wr);

  always_comb
  begin
    case (cmd_addr.offset)
      msip_offset_c:     rd_data = data_width_c'(msip_r);
      mtimecmp_offset_c: rd_data = mtimecmp_r;
      mtime_offset_c:    rd_data = mtime_r;
      plic_offset_c:     rd_data = data_width_c'(plic_r);
      default:           rd_data = '0;
    endcase
  end

  // A write to mtime takes precedence over the tick
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtime_r <= '0;
    end
    else if (cmd_fire && cmd_wr && (cmd_addr.offset == mtime_offset_c))
    begin
      mtime_r <= cmd_i.data;
    end
    else if (!freeze_i)
    begin
      mtime_r <= mtime_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      plic_r     <= 1'b0;
    end
    else if (cmd_fire && cmd_wr)
    begin
      case (cmd_addr.offset)
        mtimecmp_offset_c: mtimecmp_r <= cmd_i.data;
        msip_offset_c:     msip_r     <= cmd_i.data[0];
        plic_offset_c:     plic_r     <= cmd_i.data[0];
        default:           ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r <= 1'b0;
    end
    else if (cmd_fire)
    begin
      resp_v_r <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r <= '{header: cmd_i.header, data: (cmd_wr ? '0 : rd_data)};
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

  // Reset value of mtimecmp keeps the timer quiet
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;
  assign external_irq_o = plic_r;

  a_resp_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_o))
  ) else $error("clint_slice: response dropped before it was taken");

endmodule

`default_nettype wire

/* hdl/cmd_dispatch.sv */
// Command router with loopback slot
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch
  #(
    parameter logic [tile_pkg::addr_width_c-1:0] dram_base_p = tile_pkg::dram_base_default_c
  )
  (
    input  wire                    clk_i,
    input  wire                    rst_n_i,

    input  wire tile_pkg::mem_msg_t cmd_i,
    input  wire                    cmd_v_i,
    output logic                   cmd_ready_o,

    output tile_pkg::mem_msg_t     dev_cmd_o,

    output logic                   cfg_v_o,
    input  wire                    cfg_ready_i,
    output logic                   clint_v_o,
    input  wire                    clint_ready_i,
    output logic                   cache_v_o,
    input  wire                    cache_ready_i,

    output tile_pkg::mem_msg_t     lb_resp_o,
    output logic                   lb_resp_v_o,
    input  wire                    lb_resp_ready_i
  );

  import tile_pkg::*;

  local_addr_t local_addr;
  logic        is_local;
  logic        is_cfg;
  logic        is_clint;
  logic        is_cache;
  logic        is_lb;
  logic        lb_v;
  logic        lb_full_r;
  mem_header_t lb_header_r;

  assign local_addr = local_addr_t'(cmd_i.header.addr);

  // Address decode
  assign is_local = (cmd_i.header.addr < dram_base_p);
  assign is_cache = ~is_local | (local_addr.dev == cache_dev_c);
  assign is_cfg   = is_local & (local_addr.dev == cfg_dev_c);
  assign is_clint = is_local & (local_addr.dev == clint_dev_c);
  assign is_lb    = is_local & ~is_cfg & ~is_clint & ~is_cache;

  assign dev_cmd_o = cmd_i;

  assign cfg_v_o   = cmd_v_i & is_cfg;
  assign clint_v_o = cmd_v_i & is_clint;
  assign cache_v_o = cmd_v_i & is_cache;
  assign lb_v      = cmd_v_i & is_lb;

  // Ready follows whichever target the address selects
  assign cmd_ready_o = (is_cache & cache_ready_i)
                     | (is_cfg & cfg_ready_i)
                     | (is_clint & clint_ready_i)
                     | (is_lb & ~lb_full_r);

  // Loopback holds one response at a time
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      lb_full_r <= 1'b0;
    end
    else if (lb_v && !lb_full_r)
    begin
      lb_full_r <= 1'b1;
    end
    else if (lb_full_r && lb_resp_ready_i)
    begin
      lb_full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (lb_v && !lb_full_r)
    begin
      lb_header_r <= cmd_i.header;
    end
  end

  assign lb_resp_o   = '{header: lb_header_r, data: '0};
  assign lb_resp_v_o = lb_full_r;

  a_one_target: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({cfg_v_o, clint_v_o, cache_v_o, lb_v})
  ) else $error("cmd_dispatch: more than one target valid");

endmodule

`default_nettype wire

/* hdl/resp_arbiter.sv */
// Fixed-priority response merge
`timescale 1ns/1ps
`default_nettype none

module resp_arbiter
  (
    input  wire                     clk_i,
    input  wire                     rst_n_i,

    input  wire tile_pkg::mem_msg_t cache_resp_i,
    input  wire                     cache_v_i,
    output logic                    cache_ready_o,

    input  wire tile_pkg::mem_msg_t cfg_resp_i,
    input  wire                     cfg_v_i,
    output logic                    cfg_ready_o,

    input  wire tile_pkg::mem_msg_t clint_resp_i,
    input  wire                     clint_v_i,
    output logic                    clint_ready_o,

    input  wire tile_pkg::mem_msg_t lb_resp_i,
    input  wire                     lb_v_i,
    output logic                    lb_ready_o,

    output tile_pkg::mem_msg_t      resp_o,
    output logic                    resp_v_o,
    input  wire                     resp_ready_i
  );

  import tile_pkg::*;

  localparam int num_src_c = 4;

  logic [num_src_c-1:0]                        src_v;
  logic [num_src_c-1:0]                        grant;
  logic [num_src_c-1:0]                        src_ready;
  logic [num_src_c-1:0][$bits(mem_msg_t)-1:0]  src_msg;
  logic [$bits(mem_msg_t)-1:0]                 sel_msg;

  // Bit 0 wins, so cache outranks cfg, clint and loopback
  assign src_v   = {lb_v_i, clint_v_i, cfg_v_i, cache_v_i};
  assign src_msg = {lb_resp_i, clint_resp_i, cfg_resp_i, cache_resp_i};

  // Lowest set request bit
  assign grant = src_v & (~src_v + 1'b1);

  always_comb
  begin
    sel_msg = '0;
    for (int i = 0; i < num_src_c; i++)
    begin
      if (grant[i])
      begin
        sel_msg = sel_msg | src_msg[i];
      end
    end
  end

  assign resp_o   = mem_msg_t'(sel_msg);
  assign resp_v_o = |src_v;

  assign src_ready = grant & {num_src_c{resp_ready_i}};
  assign {lb_ready_o, clint_ready_o, cfg_ready_o, cache_ready_o} = src_ready;

  a_grant_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant)
  ) else $error("resp_arbiter: grant not one-hot");

endmodule

`default_nettype wire

/* hdl/tile_mem_fabric.sv */
// Tile memory-side device fabric
`timescale 1ns/1ps
`default_nettype none

module tile_mem_fabric
  #(
    parameter logic [tile_pkg::addr_width_c-1:0] dram_base_p = tile_pkg::dram_base_default_c
  )
  (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire tile_pkg::did_t     did_i,

    input  wire tile_pkg::mem_msg_t cmd_i,
    input  wire                     cmd_v_i,
    output logic                    cmd_ready_o,

    output tile_pkg::mem_msg_t      resp_o,
    output logic                    resp_v_o,
    input  wire                     resp_ready_i,

    output tile_pkg::mem_msg_t      mem_cmd_o,
    output logic                    mem_cmd_v_o,
    input  wire                     mem_cmd_ready_i,

    input  wire tile_pkg::mem_msg_t mem_resp_i,
    input  wire                     mem_resp_v_i,
    output logic                    mem_resp_ready_o,

    output logic                    timer_irq_o,
    output logic                    software_irq_o,
    output logic                    external_irq_o,
    output logic                    cfg_freeze_o
  );

  import tile_pkg::*;

  mem_msg_t dev_cmd;
  logic     cfg_v, cfg_ready, clint_v, clint_ready;
  mem_msg_t cfg_resp, clint_resp, lb_resp;
  logic     cfg_resp_v, cfg_resp_ready;
  logic     clint_resp_v, clint_resp_ready;
  logic     lb_resp_v, lb_resp_ready;

  // Cache-space commands leave the tile unchanged
  assign mem_cmd_o = dev_cmd;

  cmd_dispatch #(.dram_base_p(dram_base_p)) dispatch (
    .clk_i, .rst_n_i,
    .cmd_i, .cmd_v_i, .cmd_ready_o,
    .dev_cmd_o(dev_cmd),
    .cfg_v_o(cfg_v), .cfg_ready_i(cfg_ready),
    .clint_v_o(clint_v), .clint_ready_i(clint_ready),
    .cache_v_o(mem_cmd_v_o), .cache_ready_i(mem_cmd_ready_i),
    .lb_resp_o(lb_resp), .lb_resp_v_o(lb_resp_v), .lb_resp_ready_i(lb_resp_ready)
  );

  cfg_regs cfg (
    .clk_i, .rst_n_i,
    .cmd_i(dev_cmd), .cmd_v_i(cfg_v), .cmd_ready_o(cfg_ready),
    .resp_o(cfg_resp), .resp_v_o(cfg_resp_v), .resp_ready_i(cfg_resp_ready),
    .did_i, .freeze_o(cfg_freeze_o)
  );

  // Freeze also stops the machine timer
  clint_slice clint (
    .clk_i, .rst_n_i,
    .cmd_i(dev_cmd), .cmd_v_i(clint_v), .cmd_ready_o(clint_ready),
    .resp_o(clint_resp), .resp_v_o(clint_resp_v), .resp_ready_i(clint_resp_ready),
    .freeze_i(cfg_freeze_o),
    .timer_irq_o, .software_irq_o, .external_irq_o
  );

  resp_arbiter arb (
    .clk_i, .rst_n_i,
    .cache_resp_i(mem_resp_i), .cache_v_i(mem_resp_v_i), .cache_ready_o(mem_resp_ready_o),
    .cfg_resp_i(cfg_resp), .cfg_v_i(cfg_resp_v), .cfg_ready_o(cfg_resp_ready),
    .clint_resp_i(clint_resp), .clint_v_i(clint_resp_v), .clint_ready_o(clint_resp_ready),
    .lb_resp_i(lb_resp), .lb_v_i(lb_resp_v), .lb_ready_o(lb_resp_ready),
    .resp_o, .resp_v_o, .resp_ready_i
  );

endmodule

`default_nettype wire

/* test/tb_ref.svh */
// Reference model and compare tasks

localparam logic [addr_width_c-1:0] dram_base_c = dram_base_default_c;

// Shadow copies of the device registers and of memory
logic                    sh_freeze   = 1'b1;
logic                    sh_msip     = 1'b0;
logic                    sh_plic     = 1'b0;
logic [data_width_c-1:0] sh_mtimecmp = '1;
logic [data_width_c-1:0] sh_mem [logic [addr_width_c-1:0]];

// Unwritten memory reads back a pattern built from every address bit
function automatic logic [data_width_c-1:0] fill_data(input logic [addr_width_c-1:0] addr);
  return {addr[23:0], addr} ^ 64'h5a3c_96e1_0f87_d24b;
endfunction

// Computes the expected response and updates the shadow state on writes
function automatic mem_msg_t expect_resp(input mem_msg_t cmd, output bit known,
                                         output bit to_mem);
  logic [addr_width_c-1:0] addr;
  logic [3:0]              dev;
  logic [19:0]             ofs;
  logic                    wr;
  logic [data_width_c-1:0] d;
  addr   = cmd.header.addr;
  dev    = addr[23:20];
  ofs    = addr[19:0];
  wr     = (cmd.header.opcode == e_mem_wr);
  d      = '0;
  known  = 1'b1;
  to_mem = (addr >= dram_base_c) || (dev == cache_dev_c);
  if (to_mem)
  begin
    if (wr)
      sh_mem[addr] = cmd.data;
    else
      d = sh_mem.exists(addr) ? sh_mem[addr] : fill_data(addr);
  end
  else if (dev == cfg_dev_c)
  begin
    if (wr && (ofs == freeze_offset_c))
      sh_freeze = cmd.data[0];
    else if (!wr && (ofs == freeze_offset_c))
      d = {63'd0, sh_freeze};
    else if (!wr && (ofs == did_offset_c))
      d = {48'd0, did_i};
  end
  else if ((dev == clint_dev_c) && wr)
  begin
    case (ofs)
      msip_offset_c:     sh_msip     = cmd.data[0];
      plic_offset_c:     sh_plic     = cmd.data[0];
      mtimecmp_offset_c: sh_mtimecmp = cmd.data;
      default:           ;
    endcase
  end
  else if (dev == clint_dev_c)
  begin
    case (ofs)
      msip_offset_c:     d = {63'd0, sh_msip};
      plic_offset_c:     d = {63'd0, sh_plic};
      mtimecmp_offset_c: d = sh_mtimecmp;
      // Free-running so the timer test checks it
      mtime_offset_c:    known = 1'b0;
      default:           d = '0;
    endcase
  end
  return '{header: cmd.header, data: d};
endfunction

function automatic string msg_text(input mem_msg_t m);
  return $sformatf("op %0d addr %h size %0d data %h", m.header.opcode, m.header.addr,
                   m.header.size, m.data);
endfunction

task automatic compare_msg(input string what, input mem_msg_t got, input mem_msg_t exp);
  if (got !== exp)
  begin
    err_cnt++;
    test_err++;
    $display("[ERROR] %0t %s: got %s, expected %s", $time, what, msg_text(got),
             msg_text(exp));
  end
endtask

task automatic verify_level(input string what, input logic got, input logic exp);
  if (got !== exp)
  begin
    err_cnt++;
    test_err++;
    $display("[ERROR] %0t %s: got %b expected %b", $time, what, got, exp);
  end
endtask

/* test/tb_tile.sv */
// Tile memory fabric testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tile;

  import tile_pkg::*;

  // Rough cycle budget per test summed for the watchdog
  localparam int test_len_sum_c = 100 + 200 + 200 + 600 + 100 + 3000;

  logic     clk_i;
  logic     rst_n_i;
  did_t     did_i;
  mem_msg_t cmd_i;
  logic     cmd_v_i;
  logic     cmd_ready_o;
  mem_msg_t resp_o;
  logic     resp_v_o;
  logic     resp_ready_i;
  mem_msg_t mem_cmd_o;
  logic     mem_cmd_v_o;
  logic     mem_cmd_ready_i;
  mem_msg_t mem_resp_i;
  logic     mem_resp_v_i;
  logic     mem_resp_ready_o;
  logic     timer_irq_o;
  logic     software_irq_o;
  logic     external_irq_o;
  logic     cfg_freeze_o;

  int unsigned seed_val;
  int          err_cnt      = 0;
  int          test_err     = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  bit          rand_ready   = 1'b0;
  bit          accepted_any = 1'b0;

  // Commands waiting for their response, and commands due on the memory port
  mem_msg_t                pend_q[$];
  bit                      pend_known_q[$];
  mem_msg_t                exp_mem_q[$];
  mem_msg_t                mem_resp_q[$];
  logic [data_width_c-1:0] mem_store [logic [addr_width_c-1:0]];
  mem_msg_t                last_resp;

  `include "tb_ref.svh"

  tile_mem_fabric tile_mem_fabric_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    err_cnt++;
    test_err++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  task automatic value_error(input string msg);
    err_cnt++;
    test_err++;
    $display("[ERROR] %0t %s", $time, msg);
  endtask

  function automatic logic [addr_width_c-1:0] local_addr(input dev_id_t dev,
                                                         input dev_offset_t ofs);
    return {{tile_width_c{1'b0}}, dev, ofs};
  endfunction

  task automatic send_cmd(input mem_opcode_e op, input logic [addr_width_c-1:0] addr,
                          input logic [data_width_c-1:0] data);
    mem_msg_t m;
    mem_msg_t exp;
    bit       known;
    bit       to_mem;
    bit       taken;
    m.header.opcode = op;
    m.header.addr   = addr;
    m.header.size   = 3'd3;
    m.data          = data;
    @(posedge clk_i);
    #1;
    cmd_i   = m;
    cmd_v_i = 1'b1;
    taken   = 1'b0;
    while (!taken)
    begin
      @(negedge clk_i);
      taken = cmd_ready_o;
      if (taken)
      begin
        exp = expect_resp(m, known, to_mem);
        pend_q.push_back(exp);
        pend_known_q.push_back(known);
        if (to_mem)
          exp_mem_q.push_back(m);
        accepted_any = 1'b1;
      end
      @(posedge clk_i);
    end
    #1;
    cmd_v_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (pend_q.size() != 0)
      @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic read_reg(input logic [addr_width_c-1:0] addr,
                          output logic [data_width_c-1:0] val);
    send_cmd(e_mem_rd, addr, '0);
    wait_idle();
    val = last_resp.data;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_err != 0)
      tests_failed++;
    $display("Test %-14s finished with %0d errors", name, test_err);
    test_err = 0;
  endtask

  // Ready inputs go random only during the back-pressure test
  initial
  begin
    resp_ready_i    = 1'b1;
    mem_cmd_ready_i = 1'b1;
    forever
    begin
      @(posedge clk_i);
      #1;
      resp_ready_i    = !rand_ready || ($urandom_range(3) != 0);
      mem_cmd_ready_i = !rand_ready || ($urandom_range(1) != 0);
    end
  end

  // Accepting side of the memory model
  initial
  begin
    mem_msg_t m;
    mem_msg_t r;
    forever
    begin
      @(negedge clk_i);
      if (rst_n_i && mem_cmd_v_o && mem_cmd_ready_i)
      begin
        m = mem_cmd_o;
        @(posedge clk_i);
        if (exp_mem_q.size() == 0)
          report_failure("command on the memory port that should have stayed local");
        else
          compare_msg("memory command", m, exp_mem_q.pop_front());
        r.header = m.header;
        r.data   = '0;
        if (m.header.opcode == e_mem_wr)
          mem_store[m.header.addr] = m.data;
        else if (mem_store.exists(m.header.addr))
          r.data = mem_store[m.header.addr];
        else
          r.data = fill_data(m.header.addr);
        mem_resp_q.push_back(r);
      end
    end
  end

  // Memory model answers after a random delay
  initial
  begin
    int unsigned dly;
    bit          taken;
    mem_resp_v_i = 1'b0;
    mem_resp_i   = '0;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (mem_resp_q.size() != 0)
      begin
        dly = $urandom_range(4);
        repeat (dly)
        begin
          @(posedge clk_i);
          #1;
        end
        mem_resp_i   = mem_resp_q.pop_front();
        mem_resp_v_i = 1'b1;
        taken        = 1'b0;
        while (!taken)
        begin
          @(negedge clk_i);
          taken = mem_resp_ready_o;
          @(posedge clk_i);
        end
        #1;
        mem_resp_v_i = 1'b0;
      end
    end
  end

  // Compare process pairs each response with a pending command by address
  initial
  begin
    mem_msg_t got;
    mem_msg_t exp;
    bit       found;
    forever
    begin
      @(negedge clk_i);
      if (rst_n_i && resp_v_o && !accepted_any)
        report_failure("response valid went high before any command was accepted");
      if (rst_n_i && resp_v_o && resp_ready_i)
      begin
        got   = resp_o;
        found = 1'b0;
        for (int i = 0; (i < pend_q.size()) && !found; i++)
        begin
          if (pend_q[i].header.addr == got.header.addr)
          begin
            exp = pend_q[i];
            if (!pend_known_q[i])
              exp.data = got.data;
            compare_msg("response", got, exp);
            pend_q.delete(i);
            pend_known_q.delete(i);
            found = 1'b1;
          end
        end
        if (!found)
          report_failure($sformatf("response for address %h has no pending command",
                                   got.header.addr));
        last_resp = got;
      end
    end
  end

  initial
  begin
    repeat (test_len_sum_c * 4) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", test_len_sum_c * 4);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    logic [data_width_c-1:0] t0;
    logic [data_width_c-1:0] t1;
    logic [addr_width_c-1:0] a;
    mem_opcode_e             op;
    int                      sel;
    seed_val = $urandom(32'h33f8);
    rst_n_i  = 1'b0;
    cmd_i    = '0;
    cmd_v_i  = 1'b0;
    did_i    = 16'h3a5c;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Freeze must still be at its reset value
    verify_level("cfg_freeze_o after reset", cfg_freeze_o, 1'b1);
    read_reg(local_addr(cfg_dev_c, freeze_offset_c), t0);
    read_reg(local_addr(cfg_dev_c, did_offset_c), t0);
    send_cmd(e_mem_wr, local_addr(cfg_dev_c, freeze_offset_c), 64'd0);
    wait_idle();
    verify_level("cfg_freeze_o after clear", cfg_freeze_o, 1'b0);
    read_reg(local_addr(cfg_dev_c, freeze_offset_c), t0);
    read_reg(local_addr(cfg_dev_c, 20'h0_0040), t0);
    end_test("configuration");

    // DRAM space and the local cache device both leave the tile
    for (int i = 0; i < 4; i++)
    begin
      a = dram_base_c + addr_width_c'(i * 8);
      send_cmd(e_mem_wr, a, {$urandom(), $urandom()});
    end
    send_cmd(e_mem_wr, local_addr(cache_dev_c, 20'h0_0100), {$urandom(), $urandom()});
    for (int i = 0; i < 5; i++)
    begin
      a = dram_base_c + addr_width_c'(i * 8);
      send_cmd(e_mem_rd, a, '0);
    end
    send_cmd(e_mem_rd, local_addr(cache_dev_c, 20'h0_0100), '0);
    send_cmd(e_mem_rd, 40'hf0_1234_5678, '0);
    wait_idle();
    end_test("cache routing");

    // Software and external interrupt levels
    send_cmd(e_mem_wr, local_addr(clint_dev_c, msip_offset_c), 64'd1);
    send_cmd(e_mem_wr, local_addr(clint_dev_c, plic_offset_c), 64'd1);
    wait_idle();
    verify_level("software_irq_o after set", software_irq_o, 1'b1);
    verify_level("external_irq_o after set", external_irq_o, 1'b1);
    read_reg(local_addr(clint_dev_c, msip_offset_c), t0);
    read_reg(local_addr(clint_dev_c, plic_offset_c), t0);
    send_cmd(e_mem_wr, local_addr(clint_dev_c, msip_offset_c), 64'd0);
    wait_idle();
    verify_level("software_irq_o after clear", software_irq_o, 1'b0);
    verify_level("external_irq_o held", external_irq_o, 1'b1);
    send_cmd(e_mem_wr, local_addr(clint_dev_c, plic_offset_c), 64'd0);
    wait_idle();
    verify_level("external_irq_o after clear", external_irq_o, 1'b0);
    read_reg(local_addr(clint_dev_c, plic_offset_c), t0);
    end_test("clint levels");

    // Timer stops while frozen
    send_cmd(e_mem_wr, local_addr(cfg_dev_c, freeze_offset_c), 64'd1);
    wait_idle();
    read_reg(local_addr(clint_dev_c, mtime_offset_c), t0);
    read_reg(local_addr(clint_dev_c, mtime_offset_c), t1);
    if (t0 != t1)
      value_error($sformatf("mtime moved while frozen, %0d then %0d", t0, t1));
    send_cmd(e_mem_wr, local_addr(cfg_dev_c, freeze_offset_c), 64'd0);
    wait_idle();
    read_reg(local_addr(clint_dev_c, mtime_offset_c), t0);
    read_reg(local_addr(clint_dev_c, mtime_offset_c), t1);
    if (t1 < t0)
      value_error($sformatf("mtime went backwards, %0d then %0d", t0, t1));
    verify_level("timer_irq_o before compare write", timer_irq_o, 1'b0);
    send_cmd(e_mem_wr, local_addr(clint_dev_c, mtimecmp_offset_c), t1 + 64'd20);
    wait_idle();
    read_reg(local_addr(clint_dev_c, mtimecmp_offset_c), t0);
    sel = 0;
    while (!timer_irq_o && (sel < 100))
    begin
      @(negedge clk_i);
      sel++;
    end
    if (!timer_irq_o)
      report_failure("timer interrupt did not rise within 100 cycles of the compare write");
    end_test("timer");

    // Unmapped local devices
    send_cmd(e_mem_rd, local_addr(4'd0, 20'h0_0010), '0);
    send_cmd(e_mem_wr, local_addr(4'd4, 20'h0_0200), 64'hdead_beef_0123_4567);
    send_cmd(e_mem_rd, local_addr(4'd9, 20'h0_bff8), '0);
    send_cmd(e_mem_rd, local_addr(4'd15, 20'h0_0008), '0);
    wait_idle();
    end_test("loopback");

    // Mixed traffic under random back-pressure
    rand_ready = 1'b1;
    for (int n = 0; n < 60; n++)
    begin
      op  = ($urandom_range(1) != 0) ? e_mem_wr : e_mem_rd;
      sel = int'($urandom_range(4));
      case (sel)
        0: a = dram_base_c + addr_width_c'($urandom_range(7) * 8);
        1: a = local_addr(cache_dev_c, 20'(8 * $urandom_range(3)));
        2: a = local_addr(cfg_dev_c, 20'(8 * $urandom_range(2)));
        3: a = local_addr(clint_dev_c, ($urandom_range(1) != 0) ? plic_offset_c : msip_offset_c);
        default: a = local_addr(dev_id_t'(4 + $urandom_range(11)), 20'h0_0020);
      endcase
      // Keep the freeze bit clear so the timer keeps running
      if ((sel == 2) && (op == e_mem_wr))
        a = local_addr(cfg_dev_c, 20'h0_0010);
      send_cmd(op, a, {$urandom(), $urandom()});
    end
    wait_idle();
    rand_ready = 1'b0;
    if (exp_mem_q.size() != 0)
      report_failure("a cache-space command never reached the memory port");
    end_test("back-pressure");

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
common/tile_pkg.sv
cfg/cfg_regs.sv
clint/clint_slice.sv
hdl/cmd_dispatch.sv
hdl/resp_arbiter.sv
hdl/tile_mem_fabric.sv
test/tb_tile.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the tile fabric testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_tile \
    -f verilog.f -o tb_tile_sim &&
  ./obj_dir/tb_tile_sim | tee /dev/stderr | grep -qx '\*\* PASS \*\*' &&
  echo "Simulation result: passed" ||
  { echo "Simulation result: failed"; exit 1; }
